// File: all.f
+incdir+.
wexDecPkg.sv
slotDecode.sv
bundleClassify.sv
laneRoute.sv
dualLanePair.sv
issueQueue.sv
wexDecoder.sv
tbWexDecoder.sv

// File: bundleClassify.sv
/* stage 1, decodes the three slots of the fetch window side by side
   and registers them with the WEX enable for the routing stage */
`include "wexDec_macros.svh"

module bundleClassify (
	input logic clock,
	input logic rst,
	input logic inValid,
	input logic [3*`WD_SLOT_W-1:0] instrWord,
	input logic srWxe,
	output logic outValid,
	output wexDecPkg::slotInfo_t slot0,
	output wexDecPkg::slotInfo_t slot1,
	output wexDecPkg::slotInfo_t slot2,
	output logic outWxe
);
	import wexDecPkg::*;

	slotInfo_t dec0;
	slotInfo_t dec1;
	slotInfo_t dec2;

	// slot 0 sits in the low word
	slotDecode uDec0 (.word(instrWord[`WD_SLOT_W-1:0]), .info(dec0));
	slotDecode uDec1 (.word(instrWord[2*`WD_SLOT_W-1:`WD_SLOT_W]), .info(dec1));
	slotDecode uDec2 (.word(instrWord[3*`WD_SLOT_W-1:2*`WD_SLOT_W]), .info(dec2));

	always_ff @(posedge clock)
	begin
		if (rst)
			outValid <= 1'b0;
		else
			outValid <= inValid;
	end

	always_ff @(posedge clock)
	begin
		if (inValid)
		begin
			slot0 <= dec0;
			slot1 <= dec1;
			slot2 <= dec2;
			outWxe <= srWxe; // WEX enable travels with its bundle
		end
	end

	// fetch must hold off while the decoder is in reset
	aNoFetchInReset: assert property (@(posedge clock) rst |-> !inValid)
		else $error("bundleClassify: instrValid high during reset");

endmodule

// File: dualLanePair.sv
/* stage 3, spreads a wide op over lanes A and B
   lane B gets the odd or even partner of each paired register */
`include "wexDec_macros.svh"

module dualLanePair (
	input logic clock,
	input logic rst,
	input logic inValid,
	input wexDecPkg::laneOp_t laneA,
	input wexDecPkg::laneOp_t laneB,
	input wexDecPkg::laneOp_t laneC,
	input wexDecPkg::bundleKind_t inKind,
	input logic [1:0] inLen,
	input logic inWide,
	input logic inMove,
	output logic outValid,
	output wexDecPkg::laneOp_t outA,
	output wexDecPkg::laneOp_t outB,
	output wexDecPkg::laneOp_t outC,
	output wexDecPkg::bundleKind_t outKind,
	output logic [1:0] outLen
);
	import wexDecPkg::*;

	laneOp_t pairB;
	laneOp_t pairC;

	always_comb
	begin
		pairB = laneB;
		pairC = laneC;
		if (inWide)
		begin
			if (inKind != SCALAR)
				pairC = laneB; // second op of WEX2 moves out of the way

			pairB = laneA;
			pairB.rn[0] = !laneA.rn[0];
			if (!inMove)
			begin
				// move class pairs Rn only
				pairB.rm[0] = !laneA.rm[0];
				pairB.ro[0] = !laneA.ro[0];
			end

			if (inKind == SCALAR)
			begin
				pairC.rm = pairB.rn;
				pairC.ro = laneA.rn;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			outValid <= 1'b0;
		else
			outValid <= inValid;
	end

	always_ff @(posedge clock)
	begin
		if (inValid)
		begin
			outA <= laneA; // lane A passes untouched
			outB <= pairB;
			outC <= pairC;
			outKind <= inKind;
			outLen <= inLen;
		end
	end

	// three-wide leaves no free lane for the pair
	aNoWideInWex3: assert property (@(posedge clock) disable iff (rst)
		inValid && inWide |-> inKind != WEX3)
		else $error("dualLanePair: wide op inside a WEX3 bundle");

endmodule

// File: issueQueue.sv
/* output queue between decode and issue, credit controlled on both sides
   a bundle leaves whenever one is queued and the consumer has a credit */
`include "wexDec_macros.svh"

module issueQueue (
	input logic clock,
	input logic rst,
	input logic inValid,
	input wexDecPkg::laneOp_t inA,
	input wexDecPkg::laneOp_t inB,
	input wexDecPkg::laneOp_t inC,
	input wexDecPkg::bundleKind_t inKind,
	input logic [1:0] inLen,
	output logic issueValid,
	output wexDecPkg::laneOp_t outA,
	output wexDecPkg::laneOp_t outB,
	output wexDecPkg::laneOp_t outC,
	output wexDecPkg::bundleKind_t outKind,
	output logic [1:0] outLen,
	input logic issueCredit,
	output logic fetchCredit
);
	import wexDecPkg::*;

	localparam int DEPTH = `WD_QUEUE_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRED_W = $clog2(`WD_ISSUE_CREDITS + 1) + 1; // headroom to catch overflow

	laneOp_t memA [DEPTH];
	laneOp_t memB [DEPTH];
	laneOp_t memC [DEPTH];
	bundleKind_t memKind [DEPTH];
	logic [1:0] memLen [DEPTH];

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic [CRED_W-1:0] credits; // consumer credits held

	function automatic logic [PTR_W-1:0] nextPtr(logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign issueValid = (count != '0) && (credits != '0);

	// head entry, shown whether issuing or not
	assign outA = memA[rdPtr];
	assign outB = memB[rdPtr];
	assign outC = memC[rdPtr];
	assign outKind = memKind[rdPtr];
	assign outLen = memLen[rdPtr];

	always_ff @(posedge clock)
	begin
		if (inValid)
		begin
			memA[wrPtr] <= inA;
			memB[wrPtr] <= inB;
			memC[wrPtr] <= inC;
			memKind[wrPtr] <= inKind;
			memLen[wrPtr] <= inLen;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			credits <= CRED_W'(`WD_ISSUE_CREDITS);
			fetchCredit <= 1'b0;
		end
		else
		begin
			if (inValid)
				wrPtr <= nextPtr(wrPtr);
			if (issueValid)
				rdPtr <= nextPtr(rdPtr);
			count <= count + CNT_W'(inValid) - CNT_W'(issueValid);
			credits <= credits + CRED_W'(issueCredit) - CRED_W'(issueValid);
			fetchCredit <= issueValid; // slot freed, hand one back to fetch
		end
	end

	// fetch credits cover every bundle still in the pipe
	aNoWriteFull: assert property (@(posedge clock) disable iff (rst)
		inValid |-> count < CNT_W'(DEPTH))
		else $error("issueQueue: write while full");

	aCreditMax: assert property (@(posedge clock) disable iff (rst)
		credits <= CRED_W'(`WD_ISSUE_CREDITS))
		else $error("issueQueue: consumer returned too many credits");

endmodule

// File: laneRoute.sv
/* stage 2, picks scalar, WEX2 or WEX3 and places the slots onto lanes A..C
   also fills the idle lanes and writes each lane's predicate condition */
`include "wexDec_macros.svh"

module laneRoute (
	input logic clock,
	input logic rst,
	input logic inValid,
	input wexDecPkg::slotInfo_t slot0,
	input wexDecPkg::slotInfo_t slot1,
	input wexDecPkg::slotInfo_t slot2,
	input logic inWxe,
	output logic outValid,
	output wexDecPkg::laneOp_t laneA,
	output wexDecPkg::laneOp_t laneB,
	output wexDecPkg::laneOp_t laneC,
	output wexDecPkg::bundleKind_t outKind,
	output logic [1:0] outLen,
	output logic outWide,
	output logic outMove
);
	import wexDecPkg::*;

	localparam logic [`WD_REG_W-1:0] ZZR = `WD_GR_ZZR;

	logic wex0;
	logic wex1;
	laneOp_t nxtA;
	laneOp_t nxtB;
	laneOp_t nxtC;
	bundleKind_t nxtKind;
	logic [1:0] nxtLen;
	logic nxtWide;
	logic nxtMove;

	// predicate sense into the top two command bits
	function automatic laneOp_t withCond(slotInfo_t s);
		laneOp_t op;
		cond_t c;
		op = s.op;
		if (s.isPred)
			c = s.predFalse ? CF : CT;
		else
			c = ALWAYS;
		op.cmd[`WD_CMD_W-1 -: 2] = c;
		return op;
	endfunction

	// idle lane, only Rm and Ro carry anything
	function automatic laneOp_t fillLane(logic [`WD_REG_W-1:0] rm, logic [`WD_REG_W-1:0] ro);
		laneOp_t op;
		op = '0;
		op.rn = ZZR;
		op.rm = rm;
		op.ro = ro;
		return op;
	endfunction

	assign wex0 = slot0.isValid && slot0.wex && inWxe;
	assign wex1 = slot1.isValid && slot1.wex && inWxe;

	always_comb
	begin
		if (wex0 && wex1)
		begin
			// three-wide, slot order reversed
			nxtA = withCond(slot2);
			nxtB = withCond(slot1);
			nxtC = withCond(slot0);
			nxtKind = WEX3;
			nxtLen = 2'd3;
			nxtWide = slot2.wide;
			nxtMove = slot2.isMove;
		end
		else if (wex0)
		begin
			nxtA = withCond(slot1);
			nxtB = withCond(slot0);
			nxtC = fillLane(slot0.op.rn, slot1.op.rn); // both Rn for the pair
			nxtKind = WEX2;
			nxtLen = 2'd2;
			nxtWide = slot1.wide;
			nxtMove = slot1.isMove;
		end
		else
		begin
			nxtA = withCond(slot0);
			nxtB = fillLane(ZZR, slot0.op.rn);
			nxtC = fillLane(ZZR, slot0.op.rn);
			nxtKind = SCALAR;
			nxtLen = 2'd1;
			nxtWide = slot0.wide;
			nxtMove = slot0.isMove;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			outValid <= 1'b0;
		else
			outValid <= inValid;
	end

	always_ff @(posedge clock)
	begin
		if (inValid)
		begin
			laneA <= nxtA;
			laneB <= nxtB;
			laneC <= nxtC;
			outKind <= nxtKind;
			outLen <= nxtLen;
			outWide <= nxtWide;
			outMove <= nxtMove;
		end
	end

endmodule

// File: slotDecode.sv
/* field decode of one 32-bit slot word, purely combinational
   unknown prefixes come out as a NOP on the zero register */
`include "wexDec_macros.svh"

module slotDecode (
	input logic [`WD_SLOT_W-1:0] word,
	output wexDecPkg::slotInfo_t info
);

	localparam logic [`WD_REG_W-1:0] ZZR = `WD_GR_ZZR;

	logic isE;
	logic isF;
	logic immForm;

	assign isE = (word[31:28] == 4'hE); // predicated
	assign isF = (word[31:28] == 4'hF); // unconditional
	assign immForm = word[0];

	always_comb
	begin
		info = '0;
		info.op.rn = ZZR;
		info.op.rm = ZZR;
		info.op.ro = ZZR;

		if (isE || isF)
		begin
			info.isValid = 1'b1;
			info.isPred = isE;
			info.predFalse = isE && word[26];
			info.wex = word[27];
			info.wide = word[1];
			info.isMove = (word[7:3] == 5'd2);

			info.op.rn = word[25:20];
			info.op.rm = word[19:14];
			info.op.cmd = {2'b00, word[7:2]}; // condition filled in later

			// Ro field doubles as the immediate
			if (immForm)
			begin
				info.op.imm = {{(`WD_IMM_W - `WD_REG_W){word[13]}}, word[13:8]};
			end
			else
			begin
				info.op.ro = word[13:8];
			end
		end
	end

endmodule

// File: tbWexDecoder.sv
/* testbench for the WEX bundle decoder, credit-paced random and directed bundles
   a reference model fills the scoreboard and concurrent assertions check every issue */
`include "wexDec_macros.svh"

module tbWexDecoder;
	timeunit 1ns;
	timeprecision 100ps;
	import wexDecPkg::*;

	typedef struct packed {
		laneOp_t a;
		laneOp_t b;
		laneOp_t c;
		bundleKind_t kind;
		logic [1:0] len;
	} bundle_t;

	localparam logic [5:0] ZZR = `WD_GR_ZZR;

	logic clock;
	logic rst;
	logic instrValid;
	logic [3*`WD_SLOT_W-1:0] instrWord;
	logic srWxe;
	logic fetchCredit;
	logic issueValid;
	logic issueCredit;
	laneOp_t laneA;
	laneOp_t laneB;
	laneOp_t laneC;
	bundleKind_t bundleKind;
	logic [1:0] bundleLen;

	bundle_t expQ[$];
	bundle_t expHead;
	int expCount;
	int fetchCredits; // what fetch may still send
	int tbCredits; // mirror of the decoder's issue credits
	int mismatchCount = 0;
	int otherCount = 0;
	logic [31:0] lfsr = 32'h3c9c_8fe7;

	wexDecoder uut (
		.clock(clock), .rst(rst), .instrValid(instrValid), .instrWord(instrWord),
		.srWxe(srWxe), .fetchCredit(fetchCredit), .issueValid(issueValid),
		.issueCredit(issueCredit), .laneA(laneA), .laneB(laneB), .laneC(laneC),
		.bundleKind(bundleKind), .bundleLen(bundleLen)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Galois LFSR, one step per bit handed out
	function automatic logic [31:0] randBits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] makeSlot(logic [3:0] pfx, logic wex, logic pf,
			logic [5:0] rn, logic [5:0] rm, logic [5:0] ro, logic [5:0] opc,
			logic wide, logic imm);
		return {pfx, wex, pf, rn, rm, ro, opc, wide, imm};
	endfunction

	// prefix mostly E or F, now and then anything
	function automatic logic [31:0] randSlot();
		logic [1:0] sel;
		logic [3:0] pfx;
		logic [27:0] body;
		sel = randBits(2);
		pfx = (sel == 2'd0 || sel == 2'd2) ? 4'hE : (sel == 2'd1) ? 4'hF : randBits(4);
		body = randBits(28);
		return {pfx, body};
	endfunction

	// one slot as its lane should read, condition already applied
	function automatic laneOp_t expectSlot(logic [31:0] w);
		laneOp_t op;
		op = '0;
		op.rn = ZZR;
		op.rm = ZZR;
		op.ro = ZZR;
		if (w[31:29] == 3'b111)
		begin
			op.rn = w[25:20];
			op.rm = w[19:14];
			if (w[0])
				op.imm = `WD_IMM_W'($signed(w[13:8]));
			else
				op.ro = w[13:8];
			op.cmd[5:0] = w[7:2];
			op.cmd[7:6] = (w[28] == 1'b1) ? ALWAYS : (w[26] ? CF : CT);
		end
		return op;
	endfunction

	function automatic bundle_t expectBundle(logic [95:0] win, logic wxe);
		bundle_t r;
		logic [31:0] s [3];
		logic [31:0] lead;
		logic chain0;
		logic chain1;
		for (int i = 0; i < 3; i++)
			s[i] = win[32*i +: 32];
		chain0 = wxe && s[0][31:29] == 3'b111 && s[0][27];
		chain1 = wxe && s[1][31:29] == 3'b111 && s[1][27];
		r = '0;
		if (chain0 && chain1)
		begin
			r.a = expectSlot(s[2]);
			r.b = expectSlot(s[1]);
			r.c = expectSlot(s[0]);
			r.kind = WEX3;
			r.len = 2'd3;
			lead = s[2];
		end
		else if (chain0)
		begin
			r.a = expectSlot(s[1]);
			r.b = expectSlot(s[0]);
			r.c = '{rn: ZZR, rm: r.b.rn, ro: r.a.rn, imm: '0, cmd: '0};
			r.kind = WEX2;
			r.len = 2'd2;
			lead = s[1];
		end
		else
		begin
			r.a = expectSlot(s[0]);
			r.b = '{rn: ZZR, rm: ZZR, ro: r.a.rn, imm: '0, cmd: '0};
			r.c = r.b;
			r.kind = SCALAR;
			r.len = 2'd1;
			lead = s[0];
		end
		// dual-lane pairing, driven by the op in lane A
		if (lead[31:29] == 3'b111 && lead[1])
		begin
			if (r.kind != SCALAR)
				r.c = r.b;
			r.b = r.a;
			r.b.rn[0] = ~r.a.rn[0];
			if (lead[7:3] != 5'd2)
			begin
				r.b.rm[0] = ~r.a.rm[0];
				r.b.ro[0] = ~r.a.ro[0];
			end
			if (r.kind == SCALAR)
			begin
				r.c.rm = r.b.rn;
				r.c.ro = r.a.rn;
			end
		end
		return r;
	endfunction

	task automatic reportMismatch(string sig, logic [$bits(laneOp_t)-1:0] expv,
			logic [$bits(laneOp_t)-1:0] gotv);
		mismatchCount++;
		$display("FAILED t=%0t %s expected %h actual %h", $time, sig, expv, gotv);
	endtask

	task automatic reportProblem(string msg);
		otherCount++;
		$display("ERROR t=%0t %s", $time, msg);
	endtask

	// scoreboard and credit bookkeeping
	always @(posedge clock)
	begin
		if (rst)
		begin
			expQ.delete();
			fetchCredits = `WD_QUEUE_DEPTH;
			tbCredits = `WD_ISSUE_CREDITS;
		end
		else
		begin
			if (issueValid && expQ.size() != 0)
				expQ.delete(0);
			if (instrValid)
				expQ.push_back(expectBundle(instrWord, srWxe));
			fetchCredits = fetchCredits + int'(fetchCredit) - int'(instrValid);
			tbCredits = tbCredits + int'(issueCredit) - int'(issueValid);
		end
		expCount = expQ.size();
		expHead = (expCount != 0) ? expQ[0] : '0;
	end

	aIssueExpected: assert property (@(posedge clock) disable iff (rst)
		issueValid |-> expCount != 0)
		else reportProblem("bundle issued with none outstanding");
	aLaneA: assert property (@(posedge clock) disable iff (rst)
		issueValid && expCount != 0 |-> laneA == expHead.a)
		else reportMismatch("laneA", $sampled(expHead.a), $sampled(laneA));
	aLaneB: assert property (@(posedge clock) disable iff (rst)
		issueValid && expCount != 0 |-> laneB == expHead.b)
		else reportMismatch("laneB", $sampled(expHead.b), $sampled(laneB));
	aLaneC: assert property (@(posedge clock) disable iff (rst)
		issueValid && expCount != 0 |-> laneC == expHead.c)
		else reportMismatch("laneC", $sampled(expHead.c), $sampled(laneC));
	aKind: assert property (@(posedge clock) disable iff (rst)
		issueValid && expCount != 0 |-> bundleKind == expHead.kind)
		else reportMismatch("bundleKind", $sampled(expHead.kind), $sampled(bundleKind));
	aLen: assert property (@(posedge clock) disable iff (rst)
		issueValid && expCount != 0 |-> bundleLen == expHead.len)
		else reportMismatch("bundleLen", $sampled(expHead.len), $sampled(bundleLen));
	aCreditHeld: assert property (@(posedge clock) disable iff (rst)
		issueValid |-> tbCredits != 0)
		else reportProblem("issueValid high with no issue credit");
	aFetchReturn: assert property (@(posedge clock) disable iff (rst)
		fetchCredit == $past(issueValid))
		else reportProblem("fetchCredit does not follow a dequeue");
	aResetQuiet: assert property (@(posedge clock) rst |=> !issueValid && !fetchCredit)
		else reportProblem("issueValid or fetchCredit high after reset");
	// empty pipe and a credit in hand gives the 4-cycle path
	aMinLatency: assert property (@(posedge clock) disable iff (rst)
		instrValid && expCount == 0 && tbCredits != 0 |-> ##1 !issueValid [*3] ##1 issueValid)
		else reportProblem("bundle did not issue 4 cycles after acceptance");

	// one cycle on the falling edge, with a random credit return
	task automatic stepCycle();
		@(negedge clock);
		instrValid = 1'b0;
		issueCredit = (tbCredits < `WD_ISSUE_CREDITS) && randBits(1);
	endtask

	task automatic sendBundle(logic [95:0] win, logic wxe);
		int waited;
		waited = 0;
		while (fetchCredits == 0 && waited < 100)
		begin
			stepCycle();
			waited++;
		end
		if (fetchCredits == 0)
			reportProblem("timed out waiting for a fetch credit");
		instrValid = 1'b1;
		instrWord = win;
		srWxe = wxe;
		stepCycle();
	endtask

	task automatic drainQueue();
		int waited;
		waited = 0;
		while (expQ.size() != 0 && waited < 300)
		begin
			stepCycle();
			waited++;
		end
		if (expQ.size() != 0)
			reportProblem("timed out waiting for outstanding bundles to issue");
	endtask

	initial
	begin
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		rst = 1'b1;
		instrValid = 1'b0;
		instrWord = '0;
		srWxe = 1'b0;
		issueCredit = 1'b0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;

		// scalar F first, pipe empty
		sendBundle({64'h0, makeSlot(4'hF, 0, 0, 6'd5, 6'd9, 6'd12, 6'h11, 0, 0)}, 1'b1);
		drainQueue();
		sendBundle({64'h0, makeSlot(4'h3, 1, 0, 6'd7, 6'd8, 6'd9, 6'h0c, 0, 0)}, 1'b1);
		sendBundle({64'h0, makeSlot(4'hE, 0, 0, 6'd1, 6'd2, 6'h2a, 6'h13, 0, 1)}, 1'b1);
		sendBundle({64'h0, makeSlot(4'hE, 0, 1, 6'd3, 6'd4, 6'd6, 6'h14, 0, 0)}, 1'b1);
		// WEX2 and WEX3, then the same words with WEX disabled
		w0 = makeSlot(4'hE, 1, 1, 6'd10, 6'd11, 6'd12, 6'h20, 0, 0);
		w1 = makeSlot(4'hF, 0, 0, 6'd20, 6'd21, 6'd22, 6'h21, 0, 0);
		sendBundle({32'h0, w1, w0}, 1'b1);
		w1[27] = 1'b1;
		w2 = makeSlot(4'hE, 0, 0, 6'd30, 6'd31, 6'd32, 6'h22, 0, 0);
		sendBundle({w2, w1, w0}, 1'b1);
		sendBundle({w2, w1, w0}, 1'b0);
		// wide ops, move class and not
		sendBundle({64'h0, makeSlot(4'hF, 0, 0, 6'd14, 6'd17, 6'd18, 6'h05, 1, 0)}, 1'b1);
		sendBundle({64'h0, makeSlot(4'hE, 0, 1, 6'd14, 6'd17, 6'd18, 6'h21, 1, 0)}, 1'b1);
		w1 = makeSlot(4'hF, 0, 0, 6'd40, 6'd41, 6'd43, 6'h30, 1, 0);
		sendBundle({32'h0, w1, w0}, 1'b1);
		drainQueue();

		// random bundles, wide kept out of WEX3
		for (int n = 0; n < 80; n++)
		begin
			w0 = randSlot();
			w1 = randSlot();
			w2 = randSlot();
			if (w0[27] && w1[27])
				w2[1] = 1'b0;
			sendBundle({w2, w1, w0}, randBits(2) != 2'd0);
		end
		drainQueue();
		repeat (4) stepCycle();

		$display("errors: %0d value mismatches, %0d other failures", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// hard stop if everything else stalls
	initial
	begin
		#200000;
		$display("simulation watchdog expired");
		$display("sim failed");
		$finish;
	end

endmodule

// File: wexDecPkg.sv
/* lane operation, decoded slot and condition types shared by the decoder stages
   compile ahead of every module that names them */
`include "wexDec_macros.svh"

package wexDecPkg;

	// one lane's operation as handed to execute
	typedef struct packed {
		logic [`WD_REG_W-1:0] rn;
		logic [`WD_REG_W-1:0] rm;
		logic [`WD_REG_W-1:0] ro;
		logic [`WD_IMM_W-1:0] imm;
		logic [`WD_CMD_W-1:0] cmd; // [7:6] condition, [5:0] opcode
	} laneOp_t;

	// decoded slot, condition bits of op.cmd still zero
	typedef struct packed {
		laneOp_t op;
		logic isPred; // E prefix
		logic predFalse; // execute-if-false
		logic wex;
		logic wide; // dual-lane op
		logic isValid; // E or F prefix seen
		logic isMove; // opcode[5:1] == 2
	} slotInfo_t;

	typedef enum logic [1:0] {
		ALWAYS = 2'b00,
		CT = 2'b10,
		CF = 2'b11
	} cond_t;

	typedef enum logic [1:0] {
		SCALAR,
		WEX2,
		WEX3
	} bundleKind_t;

endpackage

// File: wexDec_macros.svh
/* widths, queue depth and credit counts for the bundle decoder
   include wherever one of these values is needed */
`ifndef WEXDEC_MACROS_SVH
`define WEXDEC_MACROS_SVH

// register number width
`define WD_REG_W 6

// sign-extended immediate
`define WD_IMM_W 33

// 2 condition bits over a 6-bit opcode
`define WD_CMD_W 8

// one slot of the fetch window
`define WD_SLOT_W 32

// queue entries, also fetch credits after reset
`define WD_QUEUE_DEPTH 4

`define WD_ISSUE_CREDITS 2 // consumer credits after reset

// zero register
`define WD_GR_ZZR 63

`endif

// File: wexDecoder.sv
/* three-slot WEX bundle decoder, fetch window in and lanes A..C out
   classify, route, pair, then queue for issue */
`include "wexDec_macros.svh"

module wexDecoder (
	input logic clock,
	input logic rst,
	input logic instrValid,
	input logic [3*`WD_SLOT_W-1:0] instrWord,
	input logic srWxe,
	output logic fetchCredit,
	output logic issueValid,
	input logic issueCredit,
	output wexDecPkg::laneOp_t laneA,
	output wexDecPkg::laneOp_t laneB,
	output wexDecPkg::laneOp_t laneC,
	output wexDecPkg::bundleKind_t bundleKind,
	output logic [1:0] bundleLen
);
	import wexDecPkg::*;

	// stage 1 to 2
	logic s1Valid;
	slotInfo_t s1Slot0;
	slotInfo_t s1Slot1;
	slotInfo_t s1Slot2;
	logic s1Wxe;

	// stage 2 to 3
	logic s2Valid;
	laneOp_t s2A;
	laneOp_t s2B;
	laneOp_t s2C;
	bundleKind_t s2Kind;
	logic [1:0] s2Len;
	logic s2Wide;
	logic s2Move;

	// stage 3 to queue
	logic s3Valid;
	laneOp_t s3A;
	laneOp_t s3B;
	laneOp_t s3C;
	bundleKind_t s3Kind;
	logic [1:0] s3Len;

	bundleClassify uClassify (
		.clock(clock), .rst(rst), .inValid(instrValid), .instrWord(instrWord),
		.srWxe(srWxe), .outValid(s1Valid), .slot0(s1Slot0), .slot1(s1Slot1),
		.slot2(s1Slot2), .outWxe(s1Wxe)
	);

	laneRoute uRoute (
		.clock(clock), .rst(rst), .inValid(s1Valid), .slot0(s1Slot0),
		.slot1(s1Slot1), .slot2(s1Slot2), .inWxe(s1Wxe), .outValid(s2Valid),
		.laneA(s2A), .laneB(s2B), .laneC(s2C), .outKind(s2Kind), .outLen(s2Len),
		.outWide(s2Wide), .outMove(s2Move)
	);

	dualLanePair uPair (
		.clock(clock), .rst(rst), .inValid(s2Valid), .laneA(s2A), .laneB(s2B),
		.laneC(s2C), .inKind(s2Kind), .inLen(s2Len), .inWide(s2Wide),
		.inMove(s2Move), .outValid(s3Valid), .outA(s3A), .outB(s3B), .outC(s3C),
		.outKind(s3Kind), .outLen(s3Len)
	);

	issueQueue uQueue (
		.clock(clock), .rst(rst), .inValid(s3Valid), .inA(s3A), .inB(s3B),
		.inC(s3C), .inKind(s3Kind), .inLen(s3Len), .issueValid(issueValid),
		.outA(laneA), .outB(laneB), .outC(laneC), .outKind(bundleKind),
		.outLen(bundleLen), .issueCredit(issueCredit), .fetchCredit(fetchCredit)
	);

endmodule
